/* design/mips_pkg.sv */
`default_nettype none

package mips_pkg;

        // first fetch after reset, kseg1 boot rom
        localparam logic [31:0] reset_vector = 32'hBFC00000;

        // a fetch from here ends the run
        localparam logic [31:0] halt_address = 32'h00000000;

        // major opcodes, instr[31:26]
        typedef enum logic [5:0] {
                op_special = 6'h00,
                op_addiu   = 6'h09,
                op_lw      = 6'h23,
                op_sw      = 6'h2b
        } opcode_t;

        // special function codes, instr[5:0]
        typedef enum logic [5:0] {
                fn_sll  = 6'h00,
                fn_jr   = 6'h08,
                fn_jalr = 6'h09,
                fn_addu = 6'h21,
                fn_subu = 6'h23,
                fn_and  = 6'h24,
                fn_or   = 6'h25
        } funct_t;

        typedef enum logic [2:0] {
                alu_add,
                alu_sub,
                alu_and,
                alu_or,
                alu_sll,
                alu_pass_b      // link value goes straight through
        } alu_op_t;

        // decoded control for one instruction
        typedef struct packed {
                alu_op_t    alu_op;
                logic       use_imm;    // operand b is the sign-extended immediate
                logic       reg_write;
                logic [4:0] dest;
                logic       mem_read;
                logic       mem_write;
                logic       jump_reg;   // target from rs
                logic       link;       // write pc+8 to dest
        } ctrl_t;

endpackage

`default_nettype wire

/* design/mips_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_decoder (
        input  logic [31:0]     instr,
        output mips_pkg::ctrl_t ctrl,
        output logic [4:0]      shamt,
        output logic [31:0]     imm_ext
);
        import mips_pkg::*;

        opcode_t    opcode;
        funct_t     funct;
        logic [4:0] rt;
        logic [4:0] rd;

        assign opcode  = opcode_t'(instr[31:26]);
        assign funct   = funct_t'(instr[5:0]);
        assign rt      = instr[20:16];
        assign rd      = instr[15:11];
        assign shamt   = instr[10:6];
        assign imm_ext = {{16{instr[15]}}, instr[15:0]};

        always_comb begin
                // anything not matched below stays a no-op
                ctrl           = '0;
                ctrl.alu_op    = alu_add;

                case (opcode)
                        op_special: begin
                                case (funct)
                                        fn_sll: begin
                                                ctrl.alu_op    = alu_sll;
                                                ctrl.reg_write = 1'b1;
                                                ctrl.dest      = rd;
                                        end
                                        fn_addu: begin
                                                ctrl.alu_op    = alu_add;
                                                ctrl.reg_write = 1'b1;
                                                ctrl.dest      = rd;
                                        end
                                        fn_subu: begin
                                                ctrl.alu_op    = alu_sub;
                                                ctrl.reg_write = 1'b1;
                                                ctrl.dest      = rd;
                                        end
                                        fn_and: begin
                                                ctrl.alu_op    = alu_and;
                                                ctrl.reg_write = 1'b1;
                                                ctrl.dest      = rd;
                                        end
                                        fn_or: begin
                                                ctrl.alu_op    = alu_or;
                                                ctrl.reg_write = 1'b1;
                                                ctrl.dest      = rd;
                                        end
                                        fn_jr: begin
                                                ctrl.jump_reg  = 1'b1;
                                        end
                                        fn_jalr: begin
                                                ctrl.jump_reg  = 1'b1;
                                                ctrl.link      = 1'b1;
                                                ctrl.alu_op    = alu_pass_b;
                                                ctrl.reg_write = 1'b1;
                                                ctrl.dest      = rd;  // rd is 31 by convention
                                        end
                                        default: begin
                                                ctrl.reg_write = 1'b0;
                                        end
                                endcase
                        end
                        op_addiu: begin
                                ctrl.use_imm   = 1'b1;
                                ctrl.reg_write = 1'b1;
                                ctrl.dest      = rt;
                        end
                        op_lw: begin
                                ctrl.use_imm   = 1'b1;
                                ctrl.mem_read  = 1'b1;
                                ctrl.reg_write = 1'b1;
                                ctrl.dest      = rt;
                        end
                        op_sw: begin
                                ctrl.use_imm   = 1'b1;     // address is base + offset
                                ctrl.mem_write = 1'b1;
                        end
                        default: begin
                                ctrl.reg_write = 1'b0;
                        end
                endcase
        end

endmodule

`default_nettype wire

/* design/mips_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_regfile (
        input  logic        clk,
        input  logic        reset,
        input  logic        write_en,
        input  logic [4:0]  rs_index,
        input  logic [4:0]  rt_index,
        input  logic [4:0]  rd_index,
        input  logic [31:0] write_data,
        output logic [31:0] rs_data,
        output logic [31:0] rt_data,
        output logic [31:0] v0
);

        logic [31:0] regs [0:31];

        always_ff @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < 32; i++) begin
                                regs[i] <= '0;
                        end
                end else if (write_en && rd_index != 5'd0) begin
                        regs[rd_index] <= write_data;  // $zero never written
                end
        end

        // combinational read, new value shows after the edge
        assign rs_data = regs[rs_index];
        assign rt_data = regs[rt_index];

        assign v0 = regs[2];

endmodule

`default_nettype wire

/* design/mips_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
        input  mips_pkg::alu_op_t op,
        input  logic [31:0]       a,
        input  logic [31:0]       b,
        input  logic [4:0]        shamt,
        output logic [31:0]       result
);
        import mips_pkg::*;

        always_comb begin
                case (op)
                        alu_add: begin
                                result = a + b;         // wraps, no overflow trap
                        end
                        alu_sub: begin
                                result = a - b;
                        end
                        alu_and: begin
                                result = a & b;
                        end
                        alu_or: begin
                                result = a | b;
                        end
                        alu_sll: begin
                                // sll shifts rt, which arrives on b
                                result = b << shamt;
                        end
                        alu_pass_b: begin
                                result = b;
                        end
                        default: begin
                                result = '0;
                        end
                endcase
        end

endmodule

`default_nettype wire

/* design/mips_pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_pc_unit (
        input  logic        clk,
        input  logic        reset,
        input  logic        advance,
        input  logic        jump_reg,
        input  logic [31:0] target,
        output logic [31:0] pc,
        output logic [31:0] pc_plus8,
        output logic        active
);
        import mips_pkg::*;

        logic [31:0] next_pc;   // address after the current one, holds the jump target
        logic        at_halt;

        assign at_halt  = (pc == halt_address);
        assign pc_plus8 = pc + 32'd8;

        always_ff @(posedge clk) begin
                if (reset) begin
                        pc      <= reset_vector;
                        next_pc <= reset_vector + 32'd4;
                        active  <= 1'b1;
                end else if (advance) begin
                        if (at_halt) begin
                                active <= 1'b0;         // pc and next_pc freeze here
                        end else begin
                                pc <= next_pc;
                                // the delay slot runs from next_pc first
                                if (jump_reg) begin
                                        next_pc <= target;
                                end else begin
                                        next_pc <= next_pc + 32'd4;
                                end
                        end
                end
        end

endmodule

`default_nettype wire

/* design/mips_cpu_harvard.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_harvard (
        input  logic        clk,
        input  logic        reset,
        output logic        active,
        output logic [31:0] register_v0,
        input  logic        clk_enable,
        output logic [31:0] instr_address,
        input  logic [31:0] instr_readdata,
        output logic [31:0] data_address,
        output logic        data_write,
        output logic        data_read,
        output logic [31:0] data_writedata,
        input  logic [31:0] data_readdata
);
        import mips_pkg::*;

        ctrl_t       ctrl;
        logic [4:0]  shamt;
        logic [31:0] imm_ext;
        logic [31:0] rs_data;
        logic [31:0] rt_data;
        logic [31:0] alu_b;
        logic [31:0] alu_result;
        logic [31:0] pc_plus8;
        logic [31:0] write_data;
        logic        advance;
        logic        execute;

        // step only when enabled and running, never during reset
        assign advance = clk_enable & active & ~reset;

        // the word fetched from the halt address is not executed
        assign execute = advance & (instr_address != halt_address);

        mips_decoder decoder_i (
                .instr   (instr_readdata),
                .ctrl    (ctrl),
                .shamt   (shamt),
                .imm_ext (imm_ext)
        );

        mips_regfile regfile_i (
                .clk        (clk),
                .reset      (reset),
                .write_en   (execute & ctrl.reg_write),
                .rs_index   (instr_readdata[25:21]),
                .rt_index   (instr_readdata[20:16]),
                .rd_index   (ctrl.dest),
                .write_data (write_data),
                .rs_data    (rs_data),
                .rt_data    (rt_data),
                .v0         (register_v0)
        );

        // link passes pc+8 through the alu
        always_comb begin
                if (ctrl.link) begin
                        alu_b = pc_plus8;
                end else if (ctrl.use_imm) begin
                        alu_b = imm_ext;
                end else begin
                        alu_b = rt_data;
                end
        end

        mips_alu alu_i (
                .op     (ctrl.alu_op),
                .a      (rs_data),
                .b      (alu_b),
                .shamt  (shamt),
                .result (alu_result)
        );

        assign write_data = ctrl.mem_read ? data_readdata : alu_result;

        mips_pc_unit pc_unit_i (
                .clk      (clk),
                .reset    (reset),
                .advance  (advance),
                .jump_reg (ctrl.jump_reg),
                .target   (rs_data),
                .pc       (instr_address),
                .pc_plus8 (pc_plus8),
                .active   (active)
        );

        assign data_address   = alu_result;
        assign data_writedata = rt_data;
        assign data_write     = execute & ctrl.mem_write;
        assign data_read      = execute & ctrl.mem_read;   // lw result lands at the same edge

endmodule

`default_nettype wire

/* testbench/mips_cpu_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_assert (
        input logic        clk,
        input logic        reset,
        input logic        active,
        input logic        clk_enable,
        input logic        data_read,
        input logic        data_write,
        input logic [31:0] instr_address
);

        strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
                !(data_read && data_write))
                else $error("data_read and data_write high together");

        // memory strobes only while the core steps
        strobes_gated: assert property (@(posedge clk) disable iff (reset)
                (data_read || data_write) |-> (active && clk_enable))
                else $error("memory strobe while halted or disabled");

        fetch_aligned: assert property (@(posedge clk) disable iff (reset)
                instr_address[1:0] == 2'b00)
                else $error("instr_address not word aligned");

endmodule

bind mips_cpu_harvard mips_cpu_assert assert_i (
        .clk           (clk),
        .reset         (reset),
        .active        (active),
        .clk_enable    (clk_enable),
        .data_read     (data_read),
        .data_write    (data_write),
        .instr_address (instr_address)
);

`default_nettype wire

/* testbench/mips_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_tb;
        import mips_pkg::*;

        logic        clk;
        logic        reset;
        logic        clk_enable;
        logic        active;
        logic [31:0] register_v0;
        logic [31:0] instr_address;
        logic [31:0] instr_readdata;
        logic [31:0] data_address;
        logic        data_write;
        logic        data_read;
        logic [31:0] data_writedata;
        logic [31:0] data_readdata;
        logic [31:0] rom_offset;

        logic [31:0] rom [0:127];       // boot rom at the reset vector
        logic [31:0] dmem [0:63];       // data window at 0x1000
        logic [31:0] mdmem [0:63];
        logic [31:0] mregs [0:31];

        // fetch order from the model with the data access of each fetch
        logic [31:0] exp_pc [0:1023];
        logic [1:0]  exp_kind [0:1023];  // 0 none, 1 read, 2 write
        logic [31:0] exp_addr [0:1023];
        logic [31:0] exp_wdata [0:1023];

        mips_cpu_harvard dut_i (
                .clk            (clk),
                .reset          (reset),
                .active         (active),
                .register_v0    (register_v0),
                .clk_enable     (clk_enable),
                .instr_address  (instr_address),
                .instr_readdata (instr_readdata),
                .data_address   (data_address),
                .data_write     (data_write),
                .data_read      (data_read),
                .data_writedata (data_writedata),
                .data_readdata  (data_readdata)
        );

        always #50 clk = ~clk;

        always_comb begin
                rom_offset = instr_address - reset_vector;
                if (rom_offset < 32'd512) begin
                        instr_readdata = rom[rom_offset[8:2]];
                end else begin
                        instr_readdata = 32'h0;         // the halt address reads as nop
                end
        end

        assign data_readdata = dmem[data_address[7:2]];

        always @(posedge clk) begin
                if (data_write) begin
                        dmem[data_address[7:2]] <= data_writedata;
                end
        end

        task automatic abort_run(input string why);
                $display("%s", why);
                $display("tests failed");
                $fatal(1);
        endtask

        task automatic check_value(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
                if (got !== expected) begin
                        $display("error at %0t ns: %s is %h, expected %h",
                                 $time, name, got, expected);
                        abort_run("core output differs from the reference model");
                end
        endtask

        function automatic logic [31:0] r_type(input logic [4:0] rs, input logic [4:0] rt,
                                               input logic [4:0] rd, input logic [4:0] sh,
                                               input logic [5:0] funct);
                return {6'h00, rs, rt, rd, sh, funct};
        endfunction

        function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rs,
                                               input logic [4:0] rt, input logic [15:0] imm);
                return {op, rs, rt, imm};
        endfunction

        function automatic logic [31:0] rom_word(input logic [31:0] addr);
                logic [31:0] off;
                off = addr - reset_vector;
                if (off < 32'd512) begin
                        return rom[off[8:2]];
                end
                return 32'h0;
        endfunction

        // random alu, load or store op on r0..r15 with r20 as the memory base
        function automatic logic [31:0] random_instr();
                logic [4:0]  rs;
                logic [4:0]  rt;
                logic [4:0]  rd;
                logic [4:0]  sh;
                logic [15:0] imm;
                logic [15:0] off;
                logic [31:0] w;
                int          kind;
                rs   = 5'($urandom_range(0, 15));
                rt   = 5'($urandom_range(0, 15));
                rd   = 5'($urandom_range(1, 15));
                sh   = 5'($urandom_range(0, 31));
                imm  = 16'($urandom);
                off  = {8'd0, 6'($urandom_range(0, 63)), 2'b00};
                kind = $urandom_range(0, 7);
                case (kind)
                        0:       w = i_type(6'h09, rs, rd, imm);
                        1:       w = r_type(rs, rt, rd, 5'd0, 6'h21);
                        2:       w = r_type(rs, rt, rd, 5'd0, 6'h23);
                        3:       w = r_type(rs, rt, rd, 5'd0, 6'h24);
                        4:       w = r_type(rs, rt, rd, 5'd0, 6'h25);
                        5:       w = r_type(5'd0, rt, rd, sh, 6'h00);
                        6:       w = i_type(6'h23, 5'd20, rd, off);
                        default: w = i_type(6'h2b, 5'd20, rt, off);
                endcase
                return w;
        endfunction

        task automatic clear_rom();
                for (int i = 0; i < 128; i++) begin
                        rom[i] = 32'h0;
                end
        endtask

        // jalr to word 8 with v0 = 4 in the delay slot and r5 = 40 in the subroutine
        task automatic build_fixed_program();
                clear_rom();
                rom[0]  = i_type(6'h09, 5'd0, 5'd4, 16'h5fe0);
                rom[1]  = r_type(5'd0, 5'd4, 5'd4, 5'd17, 6'h00);     // r4 = 0xbfc00000
                rom[2]  = i_type(6'h09, 5'd4, 5'd4, 16'h0020);
                rom[3]  = r_type(5'd4, 5'd0, 5'd31, 5'd0, 6'h09);
                rom[4]  = i_type(6'h09, 5'd0, 5'd2, 16'h0004);
                rom[5]  = r_type(5'd2, 5'd5, 5'd2, 5'd0, 6'h21);
                rom[6]  = r_type(5'd0, 5'd0, 5'd0, 5'd0, 6'h08);
                rom[7]  = 32'h0;
                rom[8]  = i_type(6'h09, 5'd0, 5'd5, 16'd40);
                rom[9]  = r_type(5'd31, 5'd0, 5'd0, 5'd0, 6'h08);
                rom[10] = 32'h0;
        endtask

        task automatic build_random_program();
                int pos;
                int n;
                clear_rom();
                rom[0] = i_type(6'h09, 5'd0, 5'd20, 16'h1000);
                rom[1] = i_type(6'h09, 5'd0, 5'd21, 16'h5fe0);
                rom[2] = r_type(5'd0, 5'd21, 5'd21, 5'd17, 6'h00);
                rom[3] = i_type(6'h09, 5'd21, 5'd21, 16'h0180);       // subroutine at word 96
                pos = 4;
                n = $urandom_range(4, 30);
                repeat (n) begin
                        rom[pos] = random_instr();
                        pos++;
                end
                rom[pos] = r_type(5'd21, 5'd0, 5'd31, 5'd0, 6'h09);
                rom[pos + 1] = random_instr();                          // delay slot
                pos = pos + 2;
                n = $urandom_range(4, 30);
                repeat (n) begin
                        rom[pos] = random_instr();
                        pos++;
                end
                rom[pos] = r_type(5'd0, 5'd0, 5'd0, 5'd0, 6'h08);
                rom[pos + 1] = 32'h0;
                pos = 96;
                n = $urandom_range(2, 20);
                repeat (n) begin
                        rom[pos] = random_instr();
                        pos++;
                end
                rom[pos] = r_type(5'd31, 5'd0, 5'd0, 5'd0, 6'h08);
                rom[pos + 1] = random_instr();
        endtask

        task automatic fill_data_memory();
                logic [31:0] v;
                for (int i = 0; i < 64; i++) begin
                        v = $urandom;
                        dmem[i] <= v;
                        mdmem[i] = v;
                end
        endtask

        // ISA interpreter with delay slots
        // n returns the number of fetches including the halt fetch
        task automatic run_model(output int n);
                logic [31:0] pc;
                logic [31:0] npc;
                logic [31:0] nnpc;
                logic [31:0] instr;
                logic [31:0] a;
                logic [31:0] b;
                logic [31:0] imm;
                logic [31:0] addr;
                logic [31:0] result;
                logic [4:0]  dest;
                logic        wr;
                n   = 0;
                pc  = reset_vector;
                npc = reset_vector + 32'd4;
                for (int i = 0; i < 32; i++) begin
                        mregs[i] = 32'h0;
                end
                while (pc != halt_address) begin
                        if (n >= 1000) begin
                                abort_run("reference model never reached the halt address");
                        end
                        instr  = rom_word(pc);
                        a      = mregs[instr[25:21]];
                        b      = mregs[instr[20:16]];
                        imm    = {{16{instr[15]}}, instr[15:0]};
                        nnpc   = npc + 32'd4;
                        wr     = 1'b0;
                        dest   = instr[15:11];
                        result = 32'h0;
                        addr   = a + imm;
                        exp_pc[n]    = pc;
                        exp_kind[n]  = 2'd0;
                        exp_addr[n]  = addr;
                        exp_wdata[n] = b;
                        case (instr[31:26])
                                6'h00: begin
                                        wr = 1'b1;
                                        case (instr[5:0])
                                                6'h00:   result = b << instr[10:6];
                                                6'h21:   result = a + b;
                                                6'h23:   result = a - b;
                                                6'h24:   result = a & b;
                                                6'h25:   result = a | b;
                                                6'h09:   result = pc + 32'd8;
                                                default: wr = 1'b0;
                                        endcase
                                        if (instr[5:0] == 6'h08 || instr[5:0] == 6'h09) begin
                                                nnpc = a;
                                        end
                                end
                                6'h09: begin
                                        result = a + imm;
                                        wr     = 1'b1;
                                        dest   = instr[20:16];
                                end
                                6'h23: begin
                                        exp_kind[n] = 2'd1;
                                        result      = mdmem[addr[7:2]];
                                        wr          = 1'b1;
                                        dest        = instr[20:16];
                                end
                                6'h2b: begin
                                        exp_kind[n]       = 2'd2;
                                        mdmem[addr[7:2]]  = b;
                                end
                                default: begin
                                        wr = 1'b0;
                                end
                        endcase
                        if (wr && dest != 5'd0) begin
                                mregs[dest] = result;
                        end
                        pc  = npc;
                        npc = nnpc;
                        n++;
                end
                exp_pc[n]   = pc;
                exp_kind[n] = 2'd0;
                n++;
        endtask

        task automatic run_program(input bit fixed);
                int          n_exp;
                int          fi;
                int          cycles;
                bit          held;
                bit          done;
                logic [31:0] last_pc;
                logic [31:0] last_v0;
                fill_data_memory();
                run_model(n_exp);
                @(negedge clk);
                reset      = 1'b1;
                clk_enable = 1'b1;              // strobes must stay low anyway
                repeat (8) @(negedge clk);
                check_value("instr_address", instr_address, reset_vector);
                check_value("active", 32'(active), 32'd1);
                check_value("data_read", 32'(data_read), 32'd0);
                check_value("data_write", 32'(data_write), 32'd0);
                reset      = 1'b0;
                clk_enable = 1'b0;              // first step waits for a checked cycle
                fi = 0;
                cycles = 0;
                held = 1'b0;
                done = 1'b0;
                last_pc = instr_address;
                last_v0 = register_v0;
                while (!done) begin
                        if (cycles >= 2000) begin
                                abort_run("timeout, the core did not halt within 2000 cycles");
                        end
                        @(negedge clk);
                        clk_enable = ($urandom_range(0, 3) != 0);
                        #10;
                        if (held) begin
                                check_value("instr_address", instr_address, last_pc);
                                check_value("register_v0", register_v0, last_v0);
                        end
                        if (active === 1'b0) begin
                                done = 1'b1;
                        end else if (!clk_enable) begin
                                check_value("data_read", 32'(data_read), 32'd0);
                                check_value("data_write", 32'(data_write), 32'd0);
                        end else begin
                                if (fi >= n_exp) begin
                                        abort_run("the core kept fetching past the halt address");
                                end
                                check_value("instr_address", instr_address, exp_pc[fi]);
                                check_value("data_read", 32'(data_read),
                                            32'(exp_kind[fi] == 2'd1));
                                check_value("data_write", 32'(data_write),
                                            32'(exp_kind[fi] == 2'd2));
                                if (exp_kind[fi] != 2'd0) begin
                                        check_value("data_address", data_address, exp_addr[fi]);
                                end
                                if (exp_kind[fi] == 2'd2) begin
                                        check_value("data_writedata", data_writedata,
                                                    exp_wdata[fi]);
                                end
                                fi++;
                        end
                        held = !clk_enable;
                        last_pc = instr_address;
                        last_v0 = register_v0;
                        cycles++;
                end
                check_value("fetch count", 32'(fi), 32'(n_exp));
                check_value("register_v0", register_v0, mregs[2]);
                if (fixed) begin
                        check_value("register_v0", register_v0, 32'd44);
                end
                // halted core must stay frozen
                for (int i = 0; i < 20; i++) begin
                        @(negedge clk);
                        clk_enable = ($urandom_range(0, 1) != 0);
                        #10;
                        check_value("active", 32'(active), 32'd0);
                        check_value("instr_address", instr_address, last_pc);
                        check_value("register_v0", register_v0, last_v0);
                        check_value("data_read", 32'(data_read), 32'd0);
                        check_value("data_write", 32'(data_write), 32'd0);
                end
                for (int i = 0; i < 64; i++) begin
                        check_value($sformatf("dmem[%0d]", i), dmem[i], mdmem[i]);
                end
        endtask

        initial begin
                void'($urandom(32'he0927fc7));
                clk        = 1'b0;
                reset      = 1'b1;
                clk_enable = 1'b0;
                build_fixed_program();
                run_program(1'b1);
                for (int p = 0; p < 12; p++) begin
                        build_random_program();
                        run_program(1'b0);
                end
                $display("all tests passed");
                $finish;
        end

endmodule

`default_nettype wire

/* vlog.f */
design/mips_pkg.sv
design/mips_decoder.sv
design/mips_regfile.sv
design/mips_alu.sv
design/mips_pc_unit.sv
design/mips_cpu_harvard.sv
testbench/mips_cpu_assert.sv
testbench/mips_tb.sv

/* Makefile */
TOP = mips_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f vlog.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
